//--- gecko_pkg.sv
/*
 * shared definitions for the speculation control
 * opcodes and branch condition codes, the speculation flag,
 * the branch/jump word union, and the issue, result and redirect structs
 */

package gecko_pkg;

    // two flag bits give a history of four speculation windows
    typedef logic [1:0] gecko_jump_flag_t;

    // only the opcodes that the speculation control cares about
    typedef enum logic [6:0] {
        OPCODE_OTHER  = 7'b0000000,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111
    } gecko_opcode_t;

    // funct3 encodings of the conditional branches
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // what the execute side has to do with an issued instruction
    typedef enum logic [1:0] {
        GECKO_KIND_ALU    = 2'b00,
        GECKO_KIND_BRANCH = 2'b01,
        GECKO_KIND_JUMP   = 2'b10
    } gecko_kind_t;

    // B-type layout, the branch offset is scattered over two fields
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } gecko_b_type_t;

    // J-type layout, the 20 bit jump offset in its encoded order
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } gecko_j_type_t;

    // the same instruction word seen either as a branch or as a jump
    typedef union packed {
        gecko_b_type_t b;
        gecko_j_type_t j;
    } gecko_branch_word_t;

    // instruction in flight from decode to resolve
    typedef struct packed {
        gecko_kind_t        kind;
        logic [4:0]         rd;
        logic [2:0]         funct3;
        logic [31:0]        pc;
        logic [31:0]        rs1_value;
        logic [31:0]        rs2_value;
        gecko_branch_word_t branch_word;
        gecko_jump_flag_t   flag;
    } gecko_issue_t;

    // a writeback, tagged with the flag it was issued under
    typedef struct packed {
        logic [4:0]       rd;
        logic [31:0]      value;
        gecko_jump_flag_t flag;
    } gecko_result_t;

    // new fetch target after a mispredicted branch or a jump
    typedef struct packed {
        logic [31:0] pc;
        logic        taken;
    } gecko_redirect_t;

endpackage

//--- gecko_instruction_decode.sv
/*
 * instruction decode of the speculation control
 * classifies incoming words, computes stall from the tracker levels
 * and registers accepted instructions with their speculation flag
 */

`timescale 1ns/100ps

module gecko_instruction_decode
    import gecko_pkg::*;
(
    input  wire               clk,
    input  wire               rst,

    // instruction stream
    input  wire               instr_valid,
    input  wire        [31:0] instr,
    input  wire        [31:0] instr_pc,
    input  wire        [31:0] rs1_value,
    input  wire        [31:0] rs2_value,
    input  wire               instr_updated,

    // levels from the speculation tracker
    input  wire               speculating,
    input  wire               speculation_full,
    input  wire               mispredicted,
    input  gecko_jump_flag_t  execute_flag,

    output logic              stall,

    // events toward the speculation tracker
    output logic              instruction_enable,
    output logic              instruction_branch_jump,
    output logic              instruction_updated,

    // issued instruction toward resolve
    output logic              issue_valid,
    output gecko_issue_t      issue
);

    gecko_opcode_t opcode;
    logic          is_alu;
    logic          is_branch;
    logic          is_jump;
    logic          is_branch_jump;
    logic          accept;

    always_comb begin
        opcode = gecko_opcode_t'(instr[6:0]);

        // immediate forms arrive with the immediate already in rs2_value
        is_alu         = (opcode == OPCODE_OP) || (opcode == OPCODE_OP_IMM);
        is_branch      = (opcode == OPCODE_BRANCH);
        is_jump        = (opcode == OPCODE_JAL);
        is_branch_jump = is_branch || is_jump;

        // only one branch or jump may be unresolved at a time
        // and the old stream is held off until the updated one shows up
        stall = (instr_valid && is_branch_jump && speculating) ||
                speculation_full ||
                (mispredicted && !instr_updated);

        accept = instr_valid && !stall;

        instruction_enable      = accept;
        instruction_branch_jump = accept && is_branch_jump;
        instruction_updated     = accept && instr_updated;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    // the payload simply follows every accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            if (is_branch) begin
                issue.kind <= GECKO_KIND_BRANCH;
            end else if (is_jump) begin
                issue.kind <= GECKO_KIND_JUMP;
            end else begin
                issue.kind <= GECKO_KIND_ALU;
            end

            // unknown opcodes go down the alu path with rd zero, so they never write back
            issue.rd          <= (is_alu || is_jump) ? instr[11:7] : 5'd0;
            issue.funct3      <= instr[14:12];
            issue.pc          <= instr_pc;
            issue.rs1_value   <= rs1_value;
            issue.rs2_value   <= rs2_value;
            issue.branch_word <= instr;

            // execute_flag already carries the bump of an updated stream
            issue.flag        <= execute_flag;
        end
    end

endmodule

//--- gecko_decode_speculative.sv
/*
 * speculation tracker
 * front and rear flag counters, the speculating and full levels,
 * the mispredicted state and the flag offered to new instructions
 */

`timescale 1ns/100ps

module gecko_decode_speculative
    import gecko_pkg::*;
#(
    parameter int COUNTER_WIDTH = 2
)(
    input  wire               clk,
    input  wire               rst,

    // events from decode
    input  wire               instruction_enable,
    input  wire               instruction_branch_jump,
    input  wire               instruction_updated,

    // events from resolve
    input  wire               speculation_resolved,
    input  wire               speculation_mispredicted,

    output logic              mispredicted,
    output logic              speculating,
    output logic              speculation_full,

    output gecko_jump_flag_t  execute_flag,

    output logic              reset_done
);

    localparam int FLAG_WIDTH = $bits(gecko_jump_flag_t);

    typedef logic [COUNTER_WIDTH-1:0] counter_t;

    // front counts opened windows, rear counts closed ones
    counter_t front_flag;
    counter_t rear_flag;
    counter_t front_flag_next;
    counter_t rear_flag_next;
    logic     mispredicted_next;

    always_comb begin
        // the updated stream gets its new flag in the same cycle it is accepted
        // rather than one cycle later when the front counter has moved
        execute_flag = front_flag[FLAG_WIDTH-1:0] +
                       (instruction_updated ? gecko_jump_flag_t'(1) : gecko_jump_flag_t'(0));

        // a mispredict holds until the redirected stream is taken in
        if (speculation_resolved && speculation_mispredicted) begin
            mispredicted_next = 1'b1;
        end else if (instruction_enable && instruction_updated) begin
            mispredicted_next = 1'b0;
        end else begin
            mispredicted_next = mispredicted;
        end

        // one step per branch or jump and one per updated stream
        front_flag_next = front_flag +
                          counter_t'(instruction_branch_jump) +
                          counter_t'(instruction_updated);

        // one step per resolution and one per applied stream update
        rear_flag_next = rear_flag +
                         counter_t'(speculation_resolved) +
                         counter_t'(instruction_enable && instruction_updated);

        speculating      = (front_flag != rear_flag);

        // one more step at the front would wrap onto the rear
        speculation_full = ((front_flag + counter_t'(1)) == rear_flag);
    end

    // front only moves with an accepted instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            front_flag <= '0;
        end else if (instruction_enable) begin
            front_flag <= front_flag_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rear_flag    <= '0;
            mispredicted <= 1'b0;
        end else begin
            rear_flag    <= rear_flag_next;
            mispredicted <= mispredicted_next;
        end
    end

    // goes high on the first cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            reset_done <= 1'b0;
        end else begin
            reset_done <= 1'b1;
        end
    end

endmodule

//--- gecko_branch_resolve.sv
/*
 * branch resolve and execute
 * evaluates branch conditions and jal targets, computes alu sums,
 * and registers resolution, redirect and result outputs
 */

`timescale 1ns/100ps

module gecko_branch_resolve
    import gecko_pkg::*;
(
    input  wire              clk,
    input  wire              rst,

    input  wire              issue_valid,
    input  gecko_issue_t     issue,

    // back to the tracker and the writeback filter
    output logic             speculation_resolved,
    output logic             speculation_mispredicted,

    output logic             redirect_valid,
    output gecko_redirect_t  redirect,

    output logic             result_valid,
    output gecko_result_t    result
);

    logic        is_branch;
    logic        is_jump;
    logic        branch_taken;
    logic        mispredict;
    logic [31:0] b_offset;
    logic [31:0] j_offset;
    logic [31:0] target;
    logic [31:0] link_pc;
    logic [31:0] alu_sum;
    logic        writes_back;

    always_comb begin
        is_branch = (issue.kind == GECKO_KIND_BRANCH);
        is_jump   = (issue.kind == GECKO_KIND_JUMP);

        case (issue.funct3)
            FUNCT3_BEQ:  branch_taken = (issue.rs1_value == issue.rs2_value);
            FUNCT3_BNE:  branch_taken = (issue.rs1_value != issue.rs2_value);
            FUNCT3_BLT:  branch_taken = ($signed(issue.rs1_value) < $signed(issue.rs2_value));
            FUNCT3_BGE:  branch_taken = ($signed(issue.rs1_value) >= $signed(issue.rs2_value));
            FUNCT3_BLTU: branch_taken = (issue.rs1_value < issue.rs2_value);
            FUNCT3_BGEU: branch_taken = (issue.rs1_value >= issue.rs2_value);
            default:     branch_taken = 1'b0;
        endcase

        // prediction is always not taken, so every taken branch and every jump mispredicts
        mispredict = is_jump || (is_branch && branch_taken);

        // reassemble the scattered offsets, both sign extended with bit 0 clear
        b_offset = {{20{issue.branch_word.b.imm_12}}, issue.branch_word.b.imm_11,
                    issue.branch_word.b.imm_10_5, issue.branch_word.b.imm_4_1, 1'b0};
        j_offset = {{12{issue.branch_word.j.imm_20}}, issue.branch_word.j.imm_19_12,
                    issue.branch_word.j.imm_11, issue.branch_word.j.imm_10_1, 1'b0};

        target  = issue.pc + (is_jump ? j_offset : b_offset);
        link_pc = issue.pc + 32'd4;
        alu_sum = issue.rs1_value + issue.rs2_value;

        // x0 is never written, so rd zero means no writeback at all
        writes_back = !is_branch && (issue.rd != 5'd0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            speculation_resolved     <= 1'b0;
            speculation_mispredicted <= 1'b0;
            redirect_valid           <= 1'b0;
            result_valid             <= 1'b0;
        end else begin
            speculation_resolved     <= issue_valid && (is_branch || is_jump);
            speculation_mispredicted <= issue_valid && mispredict;
            redirect_valid           <= issue_valid && mispredict;
            result_valid             <= issue_valid && writes_back;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            redirect.pc    <= target;
            redirect.taken <= mispredict;
            result.rd      <= issue.rd;
            result.value   <= is_jump ? link_pc : alu_sum;
            result.flag    <= issue.flag;
        end
    end

endmodule

//--- gecko_writeback_filter.sv
/*
 * writeback filter
 * per-flag mispredicted table with its own rear pointer,
 * drops results that were issued in the shadow of a mispredict
 */

`timescale 1ns/100ps

module gecko_writeback_filter
    import gecko_pkg::*;
(
    input  wire               clk,
    input  wire               rst,

    input  wire               speculation_resolved,
    input  wire               speculation_mispredicted,

    input  wire               instruction_updated,
    input  gecko_jump_flag_t  execute_flag,

    input  wire               result_valid,
    input  gecko_result_t     result,

    output logic              wb_valid,
    output gecko_result_t     wb
);

    localparam int HISTORY_DEPTH = 1 << $bits(gecko_jump_flag_t);

    // rear_ptr follows the tracker's rear counter step for step
    gecko_jump_flag_t          rear_ptr;
    gecko_jump_flag_t          shadow_flag;
    logic [HISTORY_DEPTH-1:0]  mispredicted_table;
    logic                      result_dropped;

    always_comb begin
        // instructions behind a branch carry the flag one past the rear pointer
        shadow_flag = rear_ptr + gecko_jump_flag_t'(1);

        // the table is looked up with the flag the result was issued under
        result_dropped = mispredicted_table[result.flag];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rear_ptr           <= '0;
            mispredicted_table <= '0;
        end else begin
            // every resolution rewrites the entry of its shadow, so stale marks
            // from an earlier pass around the flags cannot survive
            if (speculation_resolved) begin
                mispredicted_table[shadow_flag] <= speculation_mispredicted;
            end

            // the updated stream starts under a fresh flag, which must read clean
            if (instruction_updated) begin
                mispredicted_table[execute_flag] <= 1'b0;
            end

            rear_ptr <= rear_ptr + gecko_jump_flag_t'(speculation_resolved) +
                        gecko_jump_flag_t'(instruction_updated);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= result_valid && !result_dropped;
        end
    end

    // payload is only meaningful with wb_valid
    always_ff @(posedge clk) begin
        if (result_valid) begin
            wb <= result;
        end
    end

endmodule

//--- gecko_speculation_top.sv
/*
 * speculation control top level
 * connects decode, speculation tracker, branch resolve
 * and writeback filter
 */

`timescale 1ns/100ps

module gecko_speculation_top
    import gecko_pkg::*;
#(
    parameter int COUNTER_WIDTH = 2
)(
    input  wire               clk,
    input  wire               rst,

    input  wire               instr_valid,
    input  wire        [31:0] instr,
    input  wire        [31:0] instr_pc,
    input  wire        [31:0] rs1_value,
    input  wire        [31:0] rs2_value,
    input  wire               instr_updated,

    output logic              stall,

    output logic              redirect_valid,
    output gecko_redirect_t   redirect,

    output logic              wb_valid,
    output gecko_result_t     wb
);

    // decode to tracker
    logic             instruction_enable;
    logic             instruction_branch_jump;
    logic             instruction_updated;

    // tracker to decode and filter
    logic             speculating;
    logic             speculation_full;
    logic             mispredicted;
    gecko_jump_flag_t execute_flag;

    // decode to resolve
    logic             issue_valid;
    gecko_issue_t     issue;

    // resolve to tracker and filter
    logic             speculation_resolved;
    logic             speculation_mispredicted;
    logic             result_valid;
    gecko_result_t    result;

    gecko_instruction_decode decode_inst (
        .clk, .rst,
        .instr_valid, .instr, .instr_pc, .rs1_value, .rs2_value, .instr_updated,
        .speculating, .speculation_full, .mispredicted, .execute_flag,
        .stall,
        .instruction_enable, .instruction_branch_jump, .instruction_updated,
        .issue_valid, .issue
    );

    // reset_done is left open here, it only serves observation of the tracker
    gecko_decode_speculative #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) speculative_inst (
        .clk, .rst,
        .instruction_enable, .instruction_branch_jump, .instruction_updated,
        .speculation_resolved, .speculation_mispredicted,
        .mispredicted, .speculating, .speculation_full,
        .execute_flag,
        .reset_done()
    );

    gecko_branch_resolve resolve_inst (
        .clk, .rst,
        .issue_valid, .issue,
        .speculation_resolved, .speculation_mispredicted,
        .redirect_valid, .redirect,
        .result_valid, .result
    );

    gecko_writeback_filter filter_inst (
        .clk, .rst,
        .speculation_resolved, .speculation_mispredicted,
        .instruction_updated, .execute_flag,
        .result_valid, .result,
        .wb_valid, .wb
    );

endmodule

//--- gecko_speculation_checker.sv
/*
 * concurrent assertions on the speculation tracker and the writeback filter
 * one checker module, bound into both blocks with the other block's ports tied off
 */

`timescale 1ns/100ps

module gecko_speculation_checker
    import gecko_pkg::*;
#(
    parameter int COUNTER_WIDTH = 2
)(
    input  wire                     clk,
    input  wire                     rst,

    // tracker side
    input  wire [COUNTER_WIDTH-1:0] front_flag,
    input  wire [COUNTER_WIDTH-1:0] rear_flag,
    input  wire                     speculating,
    input  wire                     mispredicted,
    input  wire                     instruction_enable,
    input  wire                     instruction_updated,

    // filter side
    input  wire [3:0]               mispredicted_table,
    input  wire                     wb_valid,
    input  gecko_result_t           wb
);

    // stall lets a single branch or jump open a window, so the front leads by exactly one
    assert property (@(posedge clk) disable iff (rst)
        speculating |-> ((front_flag - rear_flag) == COUNTER_WIDTH'(1)))
        else $error("speculation window wider than one branch or jump");

    // while mispredicted, only the first instruction of the updated stream may enter
    assert property (@(posedge clk) disable iff (rst)
        (mispredicted && instruction_enable) |-> instruction_updated)
        else $error("old stream instruction accepted while mispredicted");

    // a writeback never carries a flag that the table marks as mispredicted
    assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> !mispredicted_table[wb.flag])
        else $error("writeback of a result issued under a mispredicted flag");

endmodule

bind gecko_decode_speculative gecko_speculation_checker #(
    .COUNTER_WIDTH(COUNTER_WIDTH)
) tracker_check (
    .clk, .rst,
    .front_flag, .rear_flag, .speculating, .mispredicted,
    .instruction_enable, .instruction_updated,
    .mispredicted_table(4'b0000), .wb_valid(1'b0), .wb('0)
);

bind gecko_writeback_filter gecko_speculation_checker filter_check (
    .clk, .rst,
    .front_flag(2'b00), .rear_flag(2'b00), .speculating(1'b0),
    .mispredicted(1'b0), .instruction_enable(1'b0), .instruction_updated,
    .mispredicted_table, .wb_valid, .wb
);

//--- gecko_speculation_tb.sv
/*
 * testbench for the speculation control
 * clock and reset, seeded random instruction stream that follows redirects,
 * in-order writeback and redirect model, compare task and closing report
 */

`timescale 1ns/100ps

module gecko_speculation_tb
    import gecko_pkg::*;
();

    localparam int TIMEOUT = 40;

    // stream kinds that a step can produce
    localparam int KIND_ALU       = 0;
    localparam int KIND_BRANCH    = 1;
    localparam int KIND_NOT_TAKEN = 2;
    localparam int KIND_TAKEN     = 3;
    localparam int KIND_JAL       = 4;
    localparam int KIND_MIX       = 5;

    typedef struct packed {
        logic [4:0]       rd;
        logic [31:0]      value;
        gecko_jump_flag_t flag;
        logic [31:0]      cycle;
    } expected_wb_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] cycle;
    } expected_redirect_t;

    logic            clk;
    logic            rst;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [31:0]     instr_pc;
    logic [31:0]     rs1_value;
    logic [31:0]     rs2_value;
    logic            instr_updated;
    logic            stall;
    logic            redirect_valid;
    gecko_redirect_t redirect;
    logic            wb_valid;
    gecko_result_t   wb;

    // model state, in architectural order
    expected_wb_t       wb_queue[$];
    expected_redirect_t redirect_queue[$];
    logic [31:0]        pc;
    logic [31:0]        redirect_target;
    logic [31:0]        cycle_count;
    logic [31:0]        accept_cycle;
    gecko_jump_flag_t   model_flag;
    bit                 shadow;
    bit                 updated_next;
    bit                 redirect_seen;
    int                 stall_cycles;
    int                 errors;
    int                 checks;
    int                 tests;

    gecko_speculation_top #(
        .COUNTER_WIDTH(2)
    ) UUT (
        .clk, .rst,
        .instr_valid, .instr, .instr_pc, .rs1_value, .rs2_value, .instr_updated,
        .stall,
        .redirect_valid, .redirect,
        .wb_valid, .wb
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t ns: %s", $time, what);
        finish_run();
    endtask

    // branch conditions as the base integer ISA defines them
    function automatic bit branch_taken(input logic [2:0] funct3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (funct3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // outputs are looked at on the falling edge, where they are settled
    always @(negedge clk) begin
        expected_wb_t       exp_wb;
        expected_redirect_t exp_redirect;
        if (!rst) begin
            if (wb_valid) begin
                if (wb_queue.size() == 0) begin
                    errors++;
                    $display("unexpected writeback to x%0d at %0t ns", wb.rd, $time);
                end else begin
                    exp_wb = wb_queue.pop_front();
                    compare(wb.rd, exp_wb.rd, "writeback rd");
                    compare(wb.value, exp_wb.value, "writeback value");
                    compare(wb.flag, exp_wb.flag, "writeback flag");
                    compare(cycle_count, exp_wb.cycle, "writeback cycle");
                end
            end
            if (redirect_valid) begin
                if (redirect_queue.size() == 0) begin
                    errors++;
                    $display("unexpected redirect to %h at %0t ns", redirect.pc, $time);
                    redirect_target = redirect.pc;
                end else begin
                    exp_redirect = redirect_queue.pop_front();
                    redirect_target = exp_redirect.pc;
                    compare(redirect.pc, exp_redirect.pc, "redirect target");
                    compare(redirect.taken, 1'b1, "redirect taken bit");
                    compare(cycle_count, exp_redirect.cycle, "redirect cycle");
                end
                redirect_seen = 1'b1;
            end
        end
    end

    // presents one instruction until it is accepted or its stream is redirected away
    task automatic send(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b,
                        output bit accepted);
        bit dropped;
        accepted = 1'b0;
        dropped = 1'b0;
        stall_cycles = 0;
        instr_valid   <= 1'b1;
        instr         <= word;
        instr_pc      <= pc;
        rs1_value     <= a;
        rs2_value     <= b;
        instr_updated <= updated_next;
        while (!accepted && !dropped) begin
            @(negedge clk);
            if (!stall) begin
                accepted = 1'b1;
                accept_cycle = cycle_count;
            end else begin
                stall_cycles++;
            end
            @(posedge clk);
            if (!accepted && redirect_seen && !updated_next) begin
                dropped = 1'b1;
            end else if (!accepted && stall_cycles > TIMEOUT) begin
                report_timeout("stall stayed high on one instruction");
            end
        end
    endtask

    // one instruction of the stream, with the model updated when it is accepted
    task automatic step(input int kind);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic [31:0] target;
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        bit          writes;
        bit          mispredict;
        bit          accepted;
        int          pick;
        int          roll;
        // a seen redirect restarts the stream at its target
        if (redirect_seen) begin
            pc = redirect_target;
            updated_next = 1'b1;
            redirect_seen = 1'b0;
            shadow = 1'b0;
        end
        pick = kind;
        if (kind == KIND_MIX) begin
            roll = $urandom_range(99, 0);
            pick = (roll < 60) ? KIND_ALU : ((roll < 85) ? KIND_BRANCH : KIND_JAL);
        end
        rd = 5'($urandom_range(31, 0));
        a = $urandom();
        b = $urandom();
        writes = 1'b0;
        mispredict = 1'b0;
        value = '0;
        target = '0;
        if (pick == KIND_ALU) begin
            word = {7'b0000000, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)), 3'b000,
                    rd, ($urandom_range(1, 0) == 1) ? 7'b0110011 : 7'b0010011};
            writes = (rd != 5'd0);
            value = a + b;
        end else if (pick == KIND_JAL) begin
            j_imm = {20'($urandom_range(20'hfffff, 0)), 1'b0};
            word = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], rd, 7'b1101111};
            writes = (rd != 5'd0);
            value = pc + 32'd4;
            mispredict = 1'b1;
            target = pc + {{11{j_imm[20]}}, j_imm};
        end else begin
            case ($urandom_range(5, 0))
                0:       funct3 = 3'b000;
                1:       funct3 = 3'b001;
                2:       funct3 = 3'b100;
                3:       funct3 = 3'b101;
                4:       funct3 = 3'b110;
                default: funct3 = 3'b111;
            endcase
            // equal operands on every other branch keep the taken rate near half
            if ($urandom_range(1, 0) == 1) begin
                b = a;
            end
            if (pick == KIND_NOT_TAKEN) begin
                funct3 = 3'b000;
                b = a + 32'd1;
            end else if (pick == KIND_TAKEN) begin
                funct3 = 3'b000;
                b = a;
            end
            b_imm = {12'($urandom_range(4095, 0)), 1'b0};
            word = {b_imm[12], b_imm[10:5], 5'd2, 5'd1, funct3, b_imm[4:1], b_imm[11],
                    7'b1100011};
            mispredict = branch_taken(funct3, a, b);
            target = pc + {{19{b_imm[12]}}, b_imm};
        end
        send(word, a, b, accepted);
        if (accepted) begin
            // the first instruction of an updated stream runs under a fresh flag
            if (updated_next) begin
                model_flag = model_flag + 2'd1;
            end
            updated_next = 1'b0;
            // instructions behind a mispredict are squashed, so the model skips them
            if (!shadow) begin
                if (writes) begin
                    wb_queue.push_back('{rd: rd, value: value, flag: model_flag,
                                         cycle: accept_cycle + 32'd3});
                end
                if (mispredict) begin
                    redirect_queue.push_back('{pc: target, cycle: accept_cycle + 32'd2});
                    shadow = 1'b1;
                end
            end
            // instructions behind any branch or jump carry the next flag
            if (pick != KIND_ALU) begin
                model_flag = model_flag + 2'd1;
            end
            pc = pc + 32'd4;
        end
    endtask

    task automatic run_steps(input int count, input int kind);
        repeat (count) begin
            step(kind);
        end
    endtask

    // stops the stream and waits for every expected event, then a few quiet cycles
    task automatic drain();
        int waited;
        waited = 0;
        instr_valid   <= 1'b0;
        instr_updated <= 1'b0;
        while (wb_queue.size() != 0 || redirect_queue.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("expected writebacks or redirects never arrived");
            end
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic apply_reset();
        rst           <= 1'b1;
        instr_valid   <= 1'b0;
        instr_updated <= 1'b0;
        @(posedge clk);
        // results and redirects still in flight are cleared by the first reset edge
        @(negedge clk);
        compare(redirect_valid, 1'b0, "redirect_valid during reset");
        compare(wb_valid, 1'b0, "wb_valid during reset");
        @(posedge clk);
        rst <= 1'b0;
        wb_queue.delete();
        redirect_queue.delete();
        model_flag = '0;
        shadow = 1'b0;
        updated_next = 1'b0;
        redirect_seen = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        instr_pc = '0;
        rs1_value = '0;
        rs2_value = '0;
        instr_updated = 1'b0;
        cycle_count = '0;
        accept_cycle = '0;
        redirect_target = '0;
        pc = 32'h0000_1000;
        errors = 0;
        checks = 0;
        tests = 0;
        void'($urandom(32'hea25_def9));
        apply_reset();

        run_steps(30, KIND_ALU);
        drain();
        end_test("alu stream");

        // back to back branches, the second waits for the first to resolve
        step(KIND_NOT_TAKEN);
        step(KIND_NOT_TAKEN);
        compare(stall_cycles, 2, "stall cycles of the second branch");
        run_steps(8, KIND_ALU);
        drain();
        end_test("not taken branch");

        step(KIND_TAKEN);
        run_steps(10, KIND_ALU);
        drain();
        end_test("taken branch");

        step(KIND_JAL);
        run_steps(6, KIND_ALU);
        step(KIND_JAL);
        run_steps(6, KIND_ALU);
        drain();
        end_test("jal");

        run_steps(400, KIND_MIX);
        drain();
        end_test("random mix");

        // the taken branch leaves a redirect and a mispredict pending when reset hits
        run_steps(6, KIND_ALU);
        step(KIND_TAKEN);
        apply_reset();
        @(negedge clk);
        compare(stall, 1'b0, "stall after reset");
        @(posedge clk);
        run_steps(20, KIND_ALU);
        drain();
        end_test("reset in mid-stream");

        finish_run();
    end

endmodule

//--- list.f
gecko_pkg.sv
gecko_instruction_decode.sv
gecko_decode_speculative.sv
gecko_branch_resolve.sv
gecko_writeback_filter.sv
gecko_speculation_top.sv
gecko_speculation_checker.sv
gecko_speculation_tb.sv
